// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = decode_stage_tb
FILELIST  = sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// File: include/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

`default_nettype none

// Columns: instruction word, expected op, expected imm, expected rd,
// expected flags {is_br, is_jmp, rd_mem, wr_mem, wr_reg}
typedef struct packed {
  logic [31:0] inst;
  iop_e        op;
  logic [31:0] imm;
  logic [4:0]  rd;
  logic [4:0]  flags;
} vector_t;

localparam int NUM_VECS = 20;

vector_t vectors [NUM_VECS] = '{
  '{32'hFFB10093, ADDI,    32'hFFFFFFFB, 5'd1,  5'b00001},  // addi x1, x2, -5
  '{32'h002081B3, ADD,     32'h00000000, 5'd3,  5'b00001},  // add x3, x1, x2
  '{32'h40628233, SUB,     32'h00000000, 5'd4,  5'b00001},  // sub x4, x5, x6
  '{32'h029403B3, MUL,     32'h00000000, 5'd7,  5'b00001},  // mul x7, x8, x9
  '{32'h4035D513, SRAI,    32'h00000403, 5'd10, 5'b00001},  // srai x10, x11, 3
  '{32'hABCDE637, LUI,     32'hABCDE000, 5'd12, 5'b00001},
  '{32'h00001697, AUIPC,   32'h00001000, 5'd13, 5'b00001},
  '{32'hFFC12703, LW,      32'hFFFFFFFC, 5'd14, 5'b00101},  // lw x14, -4(x2)
  '{32'hFEF12C23, SW,      32'hFFFFFFF8, 5'd24, 5'b00010},  // sw x15, -8(x2)
  '{32'hFE2088E3, BEQ,     32'hFFFFFFF0, 5'd17, 5'b10000},  // beq x1, x2, -16
  '{32'h0041F463, BGEU,    32'h00000008, 5'd8,  5'b10000},  // bgeu x3, x4, +8
  '{32'hFFDFF0EF, JAL,     32'hFFFFFFFC, 5'd1,  5'b01001},  // jal x1, -4
  '{32'h00008067, JALR,    32'h00000000, 5'd0,  5'b01000},  // Return, rd is x0
  '{32'hC00022F3, CSRR,    32'hFFFFFC00, 5'd5,  5'b00001},
  '{32'h34031073, CSRW,    32'h00000340, 5'd0,  5'b00000},
  '{32'h00000013, ADDI,    32'h00000000, 5'd0,  5'b00000},  // nop
  // Bad funct7 or funct3
  '{32'h202081B3, INVALID, 32'h00000000, 5'd3,  5'b00000},
  '{32'h0020A063, INVALID, 32'h00000000, 5'd0,  5'b00000},
  '{32'h00010083, INVALID, 32'h00000000, 5'd1,  5'b00000},  // lb is not kept
  '{32'h40109093, INVALID, 32'h00000000, 5'd1,  5'b00000}
};

`default_nettype wire

`endif

// File: bench/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb
  import decode_pkg::*;
();

`include "decode_vectors.svh"

  localparam int HALF_PERIOD = 10;
  localparam int TEST_CYCLES = 2 * NUM_VECS + 40;  // Reset, table and directed tests
  localparam int MARGIN      = 20;

  logic                clk = 1'b0;
  logic                reset;
  logic                fe_valid;
  logic [XLEN-1:0]     fe_inst;
  logic [XLEN-1:0]     fe_pc;
  logic                flush;
  logic                wb_wr_en;
  logic [REG_BITS-1:0] wb_rd;
  logic [XLEN-1:0]     wb_data;
  logic                stall;
  logic                de_valid;
  logic [XLEN-1:0]     de_pc;
  iop_e                de_op;
  logic [XLEN-1:0]     de_rs1_val;
  logic [XLEN-1:0]     de_rs2_val;
  logic [XLEN-1:0]     de_imm;
  logic [REG_BITS-1:0] de_rd;
  logic                de_is_br;
  logic                de_is_jmp;
  logic                de_rd_mem;
  logic                de_wr_mem;
  logic                de_wr_reg;

  logic [XLEN-1:0]     reg_model [NUM_REGS];  // Expected register contents
  logic [31:0]         lcg_state = 32'h963fbc40;
  logic [XLEN-1:0]     row_pc;

  decode_stage decode_stage_inst (.*);

  always #HALF_PERIOD clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // One clock of stimulus, checks follow once stall has settled
  task automatic apply_cycle(input logic valid, input logic [31:0] inst, input logic fl,
                             input logic wb_en, input logic [4:0] wb_reg,
                             input logic [31:0] wb_val);
    @(negedge clk);
    fe_valid = valid;
    fe_inst  = inst;
    flush    = fl;
    if (valid) fe_pc = fe_pc + 32'd4;
    wb_wr_en = wb_en;
    wb_rd    = wb_reg;
    wb_data  = wb_val;
    if (wb_en && (wb_reg != 5'd0)) reg_model[wb_reg] = wb_val;  // Readable from next cycle
    #(HALF_PERIOD / 2);
  endtask

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////
  initial begin
    #(2 * HALF_PERIOD * (TEST_CYCLES + MARGIN));
    $display("Timeout: the tests did not finish within the expected number of cycles");
    $display("ERRORS FOUND");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    reset    = 1'b1;
    fe_valid = 1'b0;
    fe_inst  = '0;
    fe_pc    = '0;
    flush    = 1'b0;
    wb_wr_en = 1'b0;
    wb_rd    = '0;
    wb_data  = '0;
    for (int n = 0; n < NUM_REGS; n++) begin
      reg_model[n] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    compare_value("de_valid", 32'd0, 32'(de_valid));

    //////////////////////////////////////////////////
    // Decode table, rd written back after each row
    //////////////////////////////////////////////////
    for (int i = 0; i < NUM_VECS; i++) begin
      apply_cycle(1'b1, vectors[i].inst, 1'b0, 1'b0, 5'd0, 32'd0);
      row_pc = fe_pc;
      compare_value("stall", 32'd0, 32'(stall));
      lcg_state = lcg_step(lcg_state);
      apply_cycle(1'b0, 32'd0, 1'b0, vectors[i].flags[0], vectors[i].rd, lcg_state);
      compare_value("de_valid", 32'd1, 32'(de_valid));
      compare_value("de_pc", row_pc, de_pc);
      compare_value("de_op", 32'(vectors[i].op), 32'(de_op));
      compare_value("de_imm", vectors[i].imm, de_imm);
      compare_value("de_rd", 32'(vectors[i].rd), 32'(de_rd));
      compare_value("de_is_br/is_jmp/rd_mem/wr_mem/wr_reg", 32'(vectors[i].flags),
                    32'({de_is_br, de_is_jmp, de_rd_mem, de_wr_mem, de_wr_reg}));
    end

    // Operand read through write-back, x0 stays zero
    lcg_state = lcg_step(lcg_state);
    apply_cycle(1'b0, 32'd0, 1'b0, 1'b1, 5'd6, lcg_state);
    lcg_state = lcg_step(lcg_state);
    apply_cycle(1'b0, 32'd0, 1'b0, 1'b1, 5'd7, lcg_state);
    lcg_state = lcg_step(lcg_state);
    apply_cycle(1'b0, 32'd0, 1'b0, 1'b1, 5'd0, lcg_state);
    apply_cycle(1'b1, 32'h00730433, 1'b0, 1'b0, 5'd0, 32'd0);  // add x8, x6, x7
    compare_value("stall", 32'd0, 32'(stall));
    apply_cycle(1'b0, 32'd0, 1'b0, 1'b1, 5'd8, 32'd0);
    compare_value("de_rs1_val", reg_model[6], de_rs1_val);
    compare_value("de_rs2_val", reg_model[7], de_rs2_val);
    apply_cycle(1'b1, 32'h006004B3, 1'b0, 1'b0, 5'd0, 32'd0);  // add x9, x0, x6
    apply_cycle(1'b0, 32'd0, 1'b0, 1'b1, 5'd9, 32'd0);
    compare_value("de_rs1_val", 32'd0, de_rs1_val);
    compare_value("de_rs2_val", reg_model[6], de_rs2_val);

    //////////////////////////////////////////////////
    // Read-after-write hazard on x5
    //////////////////////////////////////////////////
    apply_cycle(1'b1, 32'h00100293, 1'b0, 1'b0, 5'd0, 32'd0);  // addi x5, x0, 1
    compare_value("stall", 32'd0, 32'(stall));
    for (int n = 0; n < 3; n++) begin
      apply_cycle(1'b1, 32'h00528533, 1'b0, 1'b0, 5'd0, 32'd0);  // add x10, x5, x5
      compare_value("stall", 32'd1, 32'(stall));
      compare_value("de_valid", (n == 0) ? 32'd1 : 32'd0, 32'(de_valid));
    end
    lcg_state = lcg_step(lcg_state);
    apply_cycle(1'b1, 32'h00528533, 1'b0, 1'b1, 5'd5, lcg_state);
    compare_value("stall", 32'd1, 32'(stall));  // Bit clears on this edge
    apply_cycle(1'b1, 32'h00528533, 1'b0, 1'b0, 5'd0, 32'd0);
    compare_value("stall", 32'd0, 32'(stall));
    compare_value("de_valid", 32'd0, 32'(de_valid));
    apply_cycle(1'b0, 32'd0, 1'b0, 1'b1, 5'd10, 32'd0);
    compare_value("de_valid", 32'd1, 32'(de_valid));
    compare_value("de_op", 32'(ADD), 32'(de_op));
    compare_value("de_rs1_val", reg_model[5], de_rs1_val);
    compare_value("de_rs2_val", reg_model[5], de_rs2_val);

    // Flush gives a bubble and leaves x11 free
    apply_cycle(1'b1, 32'h00700593, 1'b1, 1'b0, 5'd0, 32'd0);  // addi x11, x0, 7
    compare_value("stall", 32'd1, 32'(stall));
    apply_cycle(1'b1, 32'h00B58633, 1'b0, 1'b0, 5'd0, 32'd0);  // add x12, x11, x11
    compare_value("de_valid", 32'd0, 32'(de_valid));
    compare_value("stall", 32'd0, 32'(stall));
    apply_cycle(1'b1, 32'h00500013, 1'b0, 1'b1, 5'd12, 32'd0);  // addi x0, x0, 5
    compare_value("de_valid", 32'd1, 32'(de_valid));
    apply_cycle(1'b1, 32'h000006B3, 1'b0, 1'b0, 5'd0, 32'd0);  // add x13, x0, x0
    compare_value("stall", 32'd0, 32'(stall));  // No pending x0
    apply_cycle(1'b0, 32'd0, 1'b0, 1'b1, 5'd13, 32'd0);
    compare_value("de_valid", 32'd1, 32'(de_valid));
    compare_value("de_rd", 32'd13, 32'(de_rd));

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
verilog/decode_pkg.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/hazard_scoreboard.sv
verilog/decode_latch.sv
verilog/decode_stage.sv
bench/decode_stage_tb.sv

// File: verilog/decode_latch.sv
`timescale 1ns/1ps
`default_nettype none

module decode_latch
  import decode_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                in_valid,
  input  logic                stall,
  input  logic [XLEN-1:0]     pc,
  input  iop_e                op,
  input  logic [XLEN-1:0]     rs1_val,
  input  logic [XLEN-1:0]     rs2_val,
  input  logic [XLEN-1:0]     imm,
  input  logic [REG_BITS-1:0] rd,
  input  logic                is_br,
  input  logic                is_jmp,
  input  logic                rd_mem,
  input  logic                wr_mem,
  input  logic                wr_reg,
  output logic                de_valid,
  output logic [XLEN-1:0]     de_pc,
  output iop_e                de_op,
  output logic [XLEN-1:0]     de_rs1_val,
  output logic [XLEN-1:0]     de_rs2_val,
  output logic [XLEN-1:0]     de_imm,
  output logic [REG_BITS-1:0] de_rd,
  output logic                de_is_br,
  output logic                de_is_jmp,
  output logic                de_rd_mem,
  output logic                de_wr_mem,
  output logic                de_wr_reg
);

  logic load;

  assign load = in_valid && !stall;

  //////////////////////////////////////////////////
  // Latch toward execute, bubble is all zeros
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset || !load) begin
      de_valid   <= 1'b0;
      de_pc      <= '0;
      de_op      <= iop_e'(0);
      de_rs1_val <= '0;
      de_rs2_val <= '0;
      de_imm     <= '0;
      de_rd      <= '0;
      de_is_br   <= 1'b0;
      de_is_jmp  <= 1'b0;
      de_rd_mem  <= 1'b0;
      de_wr_mem  <= 1'b0;
      de_wr_reg  <= 1'b0;
    end else begin
      de_valid   <= 1'b1;
      de_pc      <= pc;
      de_op      <= op;
      de_rs1_val <= rs1_val;
      de_rs2_val <= rs2_val;
      de_imm     <= imm;
      de_rd      <= rd;
      de_is_br   <= is_br;
      de_is_jmp  <= is_jmp;
      de_rd_mem  <= rd_mem;
      de_wr_mem  <= wr_mem;
      de_wr_reg  <= wr_reg;
    end
  end

  // A stalled cycle must reach execute as a bubble
  assert property (@(posedge clk) disable iff (reset) stall |=> !de_valid)
    else $error("de_valid high after a stall");

endmodule

`default_nettype wire

// File: verilog/decode_pkg.sv
`default_nettype none

package decode_pkg;

  //////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////
  localparam int XLEN     = 32;  // Data and PC width
  localparam int NUM_REGS = 32;
  localparam int REG_BITS = 5;   // Register number width

  // Internal opcodes, one per kept instruction
  typedef enum logic [5:0] {
    ADD, SUB, AND, OR, XOR, SLT, SLTU, SRA, SRL, SLL, MUL,
    ADDI, ANDI, ORI, XORI, SLTI, SLTIU, SRAI, SRLI, SLLI,
    LUI, AUIPC,
    LW, SW,
    JAL, JALR,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    CSRR, CSRW,
    INVALID
  } iop_e;

  // Immediate formats
  typedef enum logic [2:0] {
    NONE,
    I,
    S,
    B,
    U,
    J
  } imm_type_e;

  //////////////////////////////////////////////////
  // RV32 major opcodes
  //////////////////////////////////////////////////
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // ALU funct3, shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_MUL     = 3'b000;

  // Memory, jump and system funct3
  localparam logic [2:0] F3_LW   = 3'b010;
  localparam logic [2:0] F3_SW   = 3'b010;
  localparam logic [2:0] F3_JALR = 3'b000;
  localparam logic [2:0] F3_CSRR = 3'b010;  // csrrs form
  localparam logic [2:0] F3_CSRW = 3'b001;  // csrrw form

  // Branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // funct7 values
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;  // SUB and SRA
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import decode_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                fe_valid,
  input  logic [XLEN-1:0]     fe_inst,
  input  logic [XLEN-1:0]     fe_pc,
  input  logic                flush,      // Branch mispredict from execute
  input  logic                wb_wr_en,
  input  logic [REG_BITS-1:0] wb_rd,
  input  logic [XLEN-1:0]     wb_data,
  output logic                stall,      // Fetch holds while high
  output logic                de_valid,
  output logic [XLEN-1:0]     de_pc,
  output iop_e                de_op,
  output logic [XLEN-1:0]     de_rs1_val,
  output logic [XLEN-1:0]     de_rs2_val,
  output logic [XLEN-1:0]     de_imm,
  output logic [REG_BITS-1:0] de_rd,
  output logic                de_is_br,
  output logic                de_is_jmp,
  output logic                de_rd_mem,
  output logic                de_wr_mem,
  output logic                de_wr_reg
);

  // Decoder outputs
  iop_e                op;
  logic [XLEN-1:0]     imm;
  logic [REG_BITS-1:0] rs1;
  logic [REG_BITS-1:0] rs2;
  logic [REG_BITS-1:0] rd;
  logic                use_rs1;
  logic                use_rs2;
  logic                is_br;
  logic                is_jmp;
  logic                rd_mem;
  logic                wr_mem;
  logic                wr_reg;

  // Operands
  logic [XLEN-1:0]     rs1_val;
  logic [XLEN-1:0]     rs2_val;

  inst_decoder inst_decoder_inst (
    .inst    (fe_inst),
    .op      (op),
    .imm     (imm),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .use_rs1 (use_rs1),
    .use_rs2 (use_rs2),
    .is_br   (is_br),
    .is_jmp  (is_jmp),
    .rd_mem  (rd_mem),
    .wr_mem  (wr_mem),
    .wr_reg  (wr_reg)
  );

  reg_file reg_file_inst (
    .clk       (clk),
    .reset     (reset),
    .wr_en     (wb_wr_en),
    .wr_addr   (wb_rd),
    .wr_data   (wb_data),
    .rd_addr_a (rs1),
    .rd_addr_b (rs2),
    .rd_data_a (rs1_val),
    .rd_data_b (rs2_val)
  );

  hazard_scoreboard hazard_scoreboard_inst (
    .clk      (clk),
    .reset    (reset),
    .in_valid (fe_valid),
    .flush    (flush),
    .rs1      (rs1),
    .rs2      (rs2),
    .use_rs1  (use_rs1),
    .use_rs2  (use_rs2),
    .rd       (rd),
    .wr_reg   (wr_reg),
    .wb_wr_en (wb_wr_en),
    .wb_rd    (wb_rd),
    .stall    (stall)
  );

  decode_latch decode_latch_inst (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (fe_valid),
    .stall      (stall),
    .pc         (fe_pc),
    .op         (op),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .imm        (imm),
    .rd         (rd),
    .is_br      (is_br),
    .is_jmp     (is_jmp),
    .rd_mem     (rd_mem),
    .wr_mem     (wr_mem),
    .wr_reg     (wr_reg),
    .de_valid   (de_valid),
    .de_pc      (de_pc),
    .de_op      (de_op),
    .de_rs1_val (de_rs1_val),
    .de_rs2_val (de_rs2_val),
    .de_imm     (de_imm),
    .de_rd      (de_rd),
    .de_is_br   (de_is_br),
    .de_is_jmp  (de_is_jmp),
    .de_rd_mem  (de_rd_mem),
    .de_wr_mem  (de_wr_mem),
    .de_wr_reg  (de_wr_reg)
  );

endmodule

`default_nettype wire

// File: verilog/hazard_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_scoreboard
  import decode_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                in_valid,
  input  logic                flush,
  input  logic [REG_BITS-1:0] rs1,
  input  logic [REG_BITS-1:0] rs2,
  input  logic                use_rs1,
  input  logic                use_rs2,
  input  logic [REG_BITS-1:0] rd,
  input  logic                wr_reg,
  input  logic                wb_wr_en,
  input  logic [REG_BITS-1:0] wb_rd,
  output logic                stall
);

  logic [NUM_REGS-1:0] in_use;  // One bit per pending destination
  logic                hazard;
  logic                accept;

  assign hazard = (use_rs1 && in_use[rs1]) || (use_rs2 && in_use[rs2]);
  assign stall  = flush || (in_valid && hazard);
  assign accept = in_valid && !stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_use <= '0;
    end else begin
      if (wb_wr_en) in_use[wb_rd] <= 1'b0;
      if (accept && wr_reg) in_use[rd] <= 1'b1;  // Later write wins, set over clear
    end
  end

  // Decoder drops wr_reg for rd zero, so x0 is never pending
  assert property (@(posedge clk) disable iff (reset) !in_use[0])
    else $error("Scoreboard bit for x0 was set");

endmodule

`default_nettype wire

// File: verilog/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
  import decode_pkg::*;
(
  input  logic [XLEN-1:0]     inst,
  output iop_e                op,
  output logic [XLEN-1:0]     imm,
  output logic [REG_BITS-1:0] rs1,
  output logic [REG_BITS-1:0] rs2,
  output logic [REG_BITS-1:0] rd,
  output logic                use_rs1,
  output logic                use_rs2,
  output logic                is_br,
  output logic                is_jmp,
  output logic                rd_mem,
  output logic                wr_mem,
  output logic                wr_reg
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  imm_type_e  fmt;       // Immediate format of op
  logic       is_rtype;  // Register-register ALU op

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  //////////////////////////////////////////////////
  // Opcode match
  //////////////////////////////////////////////////
  always_comb begin
    op = INVALID;
    case (opcode)
      OPC_OP: begin
        if (funct7 == F7_MULDIV) begin
          if (funct3 == F3_MUL) op = MUL;
        end else if (funct7 == F7_ALT) begin
          if (funct3 == F3_ADD_SUB) op = SUB;
          else if (funct3 == F3_SRL_SRA) op = SRA;
        end else if (funct7 == F7_BASE) begin
          case (funct3)
            F3_ADD_SUB: op = ADD;
            F3_SLL:     op = SLL;
            F3_SLT:     op = SLT;
            F3_SLTU:    op = SLTU;
            F3_XOR:     op = XOR;
            F3_SRL_SRA: op = SRL;
            F3_OR:      op = OR;
            F3_AND:     op = AND;
            default:    op = INVALID;
          endcase
        end
      end
      OPC_OP_IMM: begin
        case (funct3)
          F3_ADD_SUB: op = ADDI;
          F3_SLT:     op = SLTI;
          F3_SLTU:    op = SLTIU;
          F3_XOR:     op = XORI;
          F3_OR:      op = ORI;
          F3_AND:     op = ANDI;
          F3_SLL:     op = (funct7 == F7_BASE) ? SLLI : INVALID;
          F3_SRL_SRA: begin
            if (funct7 == F7_BASE) op = SRLI;
            else if (funct7 == F7_ALT) op = SRAI;
          end
          default:    op = INVALID;
        endcase
      end
      OPC_LUI:   op = LUI;
      OPC_AUIPC: op = AUIPC;
      OPC_LOAD:  op = (funct3 == F3_LW) ? LW : INVALID;
      OPC_STORE: op = (funct3 == F3_SW) ? SW : INVALID;
      OPC_JAL:   op = JAL;
      OPC_JALR:  op = (funct3 == F3_JALR) ? JALR : INVALID;
      OPC_BRANCH: begin
        case (funct3)
          F3_BEQ:  op = BEQ;
          F3_BNE:  op = BNE;
          F3_BLT:  op = BLT;
          F3_BGE:  op = BGE;
          F3_BLTU: op = BLTU;
          F3_BGEU: op = BGEU;
          default: op = INVALID;  // 010 and 011 are reserved
        endcase
      end
      OPC_SYSTEM: begin
        if (funct3 == F3_CSRR) op = CSRR;
        else if (funct3 == F3_CSRW) op = CSRW;
      end
      default: op = INVALID;
    endcase
  end

  // Format follows from the matched op
  always_comb begin
    is_rtype = 1'b0;
    fmt      = NONE;
    case (op)
      ADD, SUB, AND, OR, XOR, SLT, SLTU, SRA, SRL, SLL, MUL: is_rtype = 1'b1;
      ADDI, ANDI, ORI, XORI, SLTI, SLTIU, SRAI, SRLI, SLLI: fmt = I;
      LW, JALR, CSRR, CSRW:                                 fmt = I;
      SW:                                                   fmt = S;
      BEQ, BNE, BLT, BGE, BLTU, BGEU:                       fmt = B;
      LUI, AUIPC:                                           fmt = U;
      JAL:                                                  fmt = J;
      default:                                              fmt = NONE;
    endcase
  end

  // Sign-extended immediate
  always_comb begin
    case (fmt)
      I:       imm = {{20{inst[31]}}, inst[31:20]};
      S:       imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      B:       imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      U:       imm = {inst[31:12], 12'b0};
      J:       imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Control flags
  //////////////////////////////////////////////////
  assign use_rs1 = is_rtype || (fmt inside {I, S, B});
  assign use_rs2 = is_rtype || (fmt inside {S, B});
  assign is_br   = (fmt == B);
  assign is_jmp  = (op == JAL) || (op == JALR);
  assign rd_mem  = (op == LW);
  assign wr_mem  = (op == SW);
  assign wr_reg  = !(op inside {SW, BEQ, BNE, BLT, BGE, BLTU, BGEU, CSRW, INVALID})
                   && (rd != '0);  // x0 target is discarded

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import decode_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                wr_en,
  input  logic [REG_BITS-1:0] wr_addr,
  input  logic [XLEN-1:0]     wr_data,
  input  logic [REG_BITS-1:0] rd_addr_a,
  input  logic [REG_BITS-1:0] rd_addr_b,
  output logic [XLEN-1:0]     rd_data_a,
  output logic [XLEN-1:0]     rd_data_b
);

  logic [XLEN-1:0] regs [NUM_REGS];

  // Single write port, x0 is never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int n = 0; n < NUM_REGS; n++) begin
        regs[n] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Asynchronous reads
  assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
  assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

`default_nettype wire
